/* verilog/sdr_pkg.sv */
package sdr_pkg;

   // SDR device geometry
   localparam int ROW_BITS = 12;
   localparam int BA_BITS = 2;
   localparam int COL_BITS = 9;
   localparam int ADDR_BITS = ROW_BITS + BA_BITS + COL_BITS;

   // One SDR word is two bus bytes
   localparam int DATA_BITS = 16;
   localparam int DATA_BYTES_LOG2 = 1;

   // Fixed burst length in beats
   localparam int BURST_WORDS = 4;

   // Row in the upper bits, column in the lowest
   typedef struct packed {
      logic [ROW_BITS-1:0] row;
      logic [BA_BITS-1:0]  bank;
      logic [COL_BITS-1:0] col;
   } sdr_addr_fields_t;

   // Arbiter writes the flat view, controller reads the fields
   typedef union packed {
      logic [ADDR_BITS-1:0] flat;
      sdr_addr_fields_t     f;
   } sdr_addr_u;

endpackage

/* verilog/bus_pkg.sv */
package bus_pkg;

   // Bus widths, data width equals the SDR word
   localparam int AW = 32;
   localparam int DW = 16;
   localparam int LEN_BITS = 4;

   // I-bus request, len is beats minus one
   typedef struct packed {
      logic [AW-1:0]       addr;
      logic                sel_bootrom;
      logic [LEN_BITS-1:0] len;
   } ibus_req_t;

   // D-bus request
   // Any set mask bit turns the burst into a full write
   typedef struct packed {
      logic [AW-1:0]       addr;
      logic [DW/8-1:0]     wmsk;
      logic [LEN_BITS-1:0] len;
   } dbus_req_t;

endpackage

/* verilog/bootrom.sv */
module bootrom
#(
   parameter int ROM_WORDS_LOG2 = 4
)
(
   input  logic                   sdr_clk,
   input  logic                   rom_en,
   input  logic [bus_pkg::AW-1:0] rom_addr,
   output logic [bus_pkg::DW-1:0] rom_dout
);

   logic [bus_pkg::DW-1:0] mem [0:(1<<ROM_WORDS_LOG2)-1];

   // Boot image
   initial
   begin
      $readmemh("boot.hex", mem);
   end

   // Low address bits only, so reads wrap around the image
   always_ff @(posedge sdr_clk)
   begin
      if (rom_en)
         rom_dout <= mem[rom_addr[ROM_WORDS_LOG2-1:0]];
   end

endmodule

/* verilog/sdr_burst_ctrl.sv */
module sdr_burst_ctrl
#(
   parameter int READ_LATENCY = 2,
   parameter int MEM_WORDS_LOG2 = 6
)
(
   input  logic                           sdr_clk,
   input  logic                           sdr_rst_n,
   input  logic                           sdr_we_req,
   output logic                           sdr_we_ack,
   input  logic                           sdr_rd_req,
   output logic                           sdr_rd_ack,
   input  sdr_pkg::sdr_addr_u             sdr_cmd,
   input  logic [sdr_pkg::DATA_BITS-1:0]  sdr_din,
   output logic [sdr_pkg::DATA_BITS-1:0]  sdr_dout,
   output logic                           sdr_r_vld,
   output logic                           sdr_w_rdy
);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_WAIT = 2'd1;
   localparam logic [1:0] S_BEAT = 2'd2;

   localparam int LAT_W = $clog2(READ_LATENCY + 1);
   localparam int BEAT_W = $clog2(sdr_pkg::BURST_WORDS);
   localparam int IDX_COL_BITS = MEM_WORDS_LOG2 - sdr_pkg::BA_BITS;
   localparam logic [LAT_W-1:0] RD_WAIT = LAT_W'(READ_LATENCY - 1);
   localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(sdr_pkg::BURST_WORDS - 1);

   logic [1:0]                      state_r;
   logic                            is_wr_r;
   logic [LAT_W-1:0]                lat_cnt_r;
   logic [BEAT_W-1:0]               beat_cnt_r;
   sdr_pkg::sdr_addr_u              cmd_r;
   logic [MEM_WORDS_LOG2-1:0]       mem_idx;
   logic [sdr_pkg::DATA_BITS-1:0]   mem [0:(1<<MEM_WORDS_LOG2)-1];

   // Bank and low column bits select the word
   assign mem_idx = {cmd_r.f.bank, cmd_r.f.col[IDX_COL_BITS-1:0]};
   assign sdr_dout = mem[mem_idx];

   always_ff @(posedge sdr_clk or negedge sdr_rst_n)
   begin
      if (!sdr_rst_n)
      begin
         state_r <= S_IDLE;
         is_wr_r <= 1'b0;
         lat_cnt_r <= '0;
         beat_cnt_r <= '0;
         sdr_we_ack <= 1'b0;
         sdr_rd_ack <= 1'b0;
         sdr_w_rdy <= 1'b0;
         sdr_r_vld <= 1'b0;
      end
      else
      begin
         case (state_r)
            S_IDLE:
               if (sdr_we_req)
               begin
                  sdr_we_ack <= 1'b1;
                  is_wr_r <= 1'b1;
                  lat_cnt_r <= '0;
                  state_r <= S_WAIT;
               end
               else if (sdr_rd_req)
               begin
                  sdr_rd_ack <= 1'b1;
                  is_wr_r <= 1'b0;
                  lat_cnt_r <= RD_WAIT;
                  state_r <= S_WAIT;
               end
            S_WAIT:
               if (lat_cnt_r == '0)
               begin
                  sdr_w_rdy <= is_wr_r;
                  sdr_r_vld <= ~is_wr_r;
                  beat_cnt_r <= LAST_BEAT;
                  state_r <= S_BEAT;
               end
               else
                  lat_cnt_r <= lat_cnt_r - 1'b1;
            S_BEAT:
               if (beat_cnt_r == '0)
               begin
                  // Ack drops right after the last beat
                  sdr_w_rdy <= 1'b0;
                  sdr_r_vld <= 1'b0;
                  sdr_we_ack <= 1'b0;
                  sdr_rd_ack <= 1'b0;
                  state_r <= S_IDLE;
               end
               else
                  beat_cnt_r <= beat_cnt_r - 1'b1;
            default:
               state_r <= S_IDLE;
         endcase
      end
   end

   // Latch the command, then step the column once per beat
   always_ff @(posedge sdr_clk)
   begin
      if (state_r == S_IDLE && (sdr_we_req || sdr_rd_req))
         cmd_r <= sdr_cmd;
      else if (state_r == S_BEAT)
         cmd_r.f.col <= cmd_r.f.col + 1'b1;
   end

   always_ff @(posedge sdr_clk)
   begin
      if (state_r == S_BEAT && sdr_w_rdy)
         mem[mem_idx] <= sdr_din;
   end

   // Arbiter never asks for both burst types at once
   a_one_req: assert property (@(posedge sdr_clk) disable iff (!sdr_rst_n)
      !(sdr_we_req && sdr_rd_req));

endmodule

/* verilog/dram_arbiter.sv */
module dram_arbiter
#(
   parameter int BYTES_PER_BEAT = 2
)
(
   input  logic                           sdr_clk,
   input  logic                           sdr_rst_n,
   // I-bus
   input  logic                           ibus_avalid,
   input  bus_pkg::ibus_req_t             ibus_req,
   output logic                           ibus_aready,
   input  logic                           ibus_bready,
   output logic                           ibus_bvalid,
   output logic [bus_pkg::DW-1:0]         ibus_bdata,
   // D-bus
   input  logic                           dbus_avalid,
   input  bus_pkg::dbus_req_t             dbus_req,
   output logic                           dbus_aready,
   input  logic [bus_pkg::DW-1:0]         dbus_wdata,
   input  logic                           dbus_bready,
   output logic                           dbus_bvalid,
   output logic [bus_pkg::DW-1:0]         dbus_bdata,
   output logic                           dbus_bwe,
   // SDR controller
   output logic                           sdr_we_req,
   input  logic                           sdr_we_ack,
   output logic                           sdr_rd_req,
   input  logic                           sdr_rd_ack,
   output sdr_pkg::sdr_addr_u             sdr_cmd,
   output logic [sdr_pkg::DATA_BITS-1:0]  sdr_din,
   input  logic [sdr_pkg::DATA_BITS-1:0]  sdr_dout,
   input  logic                           sdr_r_vld,
   input  logic                           sdr_w_rdy,
   // Boot ROM, word addressed
   output logic                           rom_en,
   output logic [bus_pkg::AW-1:0]         rom_addr,
   input  logic [bus_pkg::DW-1:0]         rom_dout
);

   localparam logic [2:0] S_IDLE        = 3'b000;
   localparam logic [2:0] S_D_START     = 3'b001;
   localparam logic [2:0] S_D_W_PENDING = 3'b010;
   localparam logic [2:0] S_D_R_PENDING = 3'b011;
   localparam logic [2:0] S_I_START     = 3'b111;
   localparam logic [2:0] S_I_R_PENDING = 3'b110;
   localparam logic [2:0] S_ROM_START   = 3'b100;
   localparam logic [2:0] S_ROM_PENDING = 3'b101;

   localparam int BEAT_SHIFT = $clog2(BYTES_PER_BEAT);
   localparam logic [bus_pkg::LEN_BITS-1:0] SDR_LEN =
      bus_pkg::LEN_BITS'(sdr_pkg::BURST_WORDS - 1);

   logic [2:0]                     state_r;
   logic [bus_pkg::LEN_BITS-1:0]   rom_cnt_r;
   logic                           sdr_start;
   logic [bus_pkg::LEN_BITS-1:0]   sdr_len;

   // D-bus has fixed priority over the I-bus
   assign dbus_aready = (state_r == S_IDLE);
   assign ibus_aready = (state_r == S_IDLE) & ~dbus_avalid;

   assign dbus_bvalid = ((state_r == S_D_W_PENDING) & sdr_w_rdy) |
                        ((state_r == S_D_R_PENDING) & sdr_r_vld);
   assign dbus_bwe = (state_r == S_D_W_PENDING) & sdr_w_rdy;
   assign dbus_bdata = sdr_dout;
   assign sdr_din = dbus_wdata;

   // ROM beats run back to back, SDR beats follow r_vld
   assign ibus_bvalid = ((state_r == S_I_R_PENDING) & sdr_r_vld) |
                        (state_r == S_ROM_PENDING);
   assign ibus_bdata = (state_r == S_ROM_PENDING) ? rom_dout : sdr_dout;

   always_ff @(posedge sdr_clk or negedge sdr_rst_n)
   begin
      if (!sdr_rst_n)
      begin
         state_r <= S_IDLE;
         sdr_we_req <= 1'b0;
         sdr_rd_req <= 1'b0;
         rom_en <= 1'b0;
         rom_cnt_r <= '0;
      end
      else
      begin
         case (state_r)
            S_IDLE:
               if (dbus_avalid)
               begin
                  sdr_we_req <= |dbus_req.wmsk;
                  sdr_rd_req <= ~|dbus_req.wmsk;
                  state_r <= S_D_START;
               end
               else if (ibus_avalid && ibus_req.sel_bootrom)
               begin
                  rom_en <= 1'b1;
                  rom_cnt_r <= ibus_req.len;
                  state_r <= S_ROM_START;
               end
               else if (ibus_avalid)
               begin
                  sdr_rd_req <= 1'b1;
                  state_r <= S_I_START;
               end
            S_D_START:
            begin
               if (sdr_we_req && sdr_we_ack)
               begin
                  sdr_we_req <= 1'b0;
                  state_r <= S_D_W_PENDING;
               end
               if (sdr_rd_req && sdr_rd_ack)
               begin
                  sdr_rd_req <= 1'b0;
                  state_r <= S_D_R_PENDING;
               end
            end
            S_D_W_PENDING:
               if (!sdr_we_ack)
                  state_r <= S_IDLE;
            S_D_R_PENDING, S_I_R_PENDING:
               if (!sdr_rd_ack)
                  state_r <= S_IDLE;
            S_I_START:
               if (sdr_rd_ack)
               begin
                  sdr_rd_req <= 1'b0;
                  state_r <= S_I_R_PENDING;
               end
            S_ROM_START:
               state_r <= S_ROM_PENDING;
            S_ROM_PENDING:
               if (|rom_cnt_r)
                  rom_cnt_r <= rom_cnt_r - 1'b1;
               else
               begin
                  rom_en <= 1'b0;
                  state_r <= S_IDLE;
               end
            default:
               state_r <= S_IDLE;
         endcase
      end
   end

   // Command address and ROM word pointer
   always_ff @(posedge sdr_clk)
   begin
      if (state_r == S_IDLE)
      begin
         if (dbus_avalid)
            sdr_cmd.flat <= dbus_req.addr[sdr_pkg::DATA_BYTES_LOG2 +: sdr_pkg::ADDR_BITS];
         else
            sdr_cmd.flat <= ibus_req.addr[sdr_pkg::DATA_BYTES_LOG2 +: sdr_pkg::ADDR_BITS];
         rom_addr <= ibus_req.addr >> BEAT_SHIFT;
      end
      else if (state_r == S_ROM_START || (state_r == S_ROM_PENDING && |rom_cnt_r))
         rom_addr <= rom_addr + 1'b1;
   end

   // An SDR burst is accepted from the idle state
   assign sdr_start = (state_r == S_IDLE) &
                      (dbus_avalid | (ibus_avalid & ~ibus_req.sel_bootrom));
   assign sdr_len = dbus_avalid ? dbus_req.len : ibus_req.len;

   // Controller answers with the ack type that was requested
   a_ack_type: assert property (@(posedge sdr_clk) disable iff (!sdr_rst_n)
      !((sdr_we_req && sdr_rd_ack) || (sdr_rd_req && sdr_we_ack)));

   // No response stall while a beat is on the bus
   a_no_bstall: assert property (@(posedge sdr_clk) disable iff (!sdr_rst_n)
      !(ibus_bvalid && !ibus_bready) && !(dbus_bvalid && !dbus_bready));

   // Cache line must match the fixed SDR burst
   a_sdr_len: assert property (@(posedge sdr_clk) disable iff (!sdr_rst_n)
      sdr_start |-> (sdr_len == SDR_LEN));

endmodule

/* verilog/dram_subsystem.sv */
module dram_subsystem
#(
   parameter int READ_LATENCY = 2,
   parameter int MEM_WORDS_LOG2 = 6,
   parameter int ROM_WORDS_LOG2 = 4
)
(
   input  logic                   sdr_clk,
   input  logic                   sdr_rst_n,
   // I-bus
   input  logic                   ibus_avalid,
   input  bus_pkg::ibus_req_t     ibus_req,
   output logic                   ibus_aready,
   input  logic                   ibus_bready,
   output logic                   ibus_bvalid,
   output logic [bus_pkg::DW-1:0] ibus_bdata,
   // D-bus
   input  logic                   dbus_avalid,
   input  bus_pkg::dbus_req_t     dbus_req,
   output logic                   dbus_aready,
   input  logic [bus_pkg::DW-1:0] dbus_wdata,
   input  logic                   dbus_bready,
   output logic                   dbus_bvalid,
   output logic [bus_pkg::DW-1:0] dbus_bdata,
   output logic                   dbus_bwe
);

   logic                          sdr_we_req;
   logic                          sdr_we_ack;
   logic                          sdr_rd_req;
   logic                          sdr_rd_ack;
   sdr_pkg::sdr_addr_u            sdr_cmd;
   logic [sdr_pkg::DATA_BITS-1:0] sdr_din;
   logic [sdr_pkg::DATA_BITS-1:0] sdr_dout;
   logic                          sdr_r_vld;
   logic                          sdr_w_rdy;
   logic                          rom_en;
   logic [bus_pkg::AW-1:0]        rom_addr;
   logic [bus_pkg::DW-1:0]        rom_dout;

   dram_arbiter #(
      .BYTES_PER_BEAT (bus_pkg::DW / 8)
   ) u_arbiter (
      .sdr_clk     (sdr_clk),
      .sdr_rst_n   (sdr_rst_n),
      .ibus_avalid (ibus_avalid),
      .ibus_req    (ibus_req),
      .ibus_aready (ibus_aready),
      .ibus_bready (ibus_bready),
      .ibus_bvalid (ibus_bvalid),
      .ibus_bdata  (ibus_bdata),
      .dbus_avalid (dbus_avalid),
      .dbus_req    (dbus_req),
      .dbus_aready (dbus_aready),
      .dbus_wdata  (dbus_wdata),
      .dbus_bready (dbus_bready),
      .dbus_bvalid (dbus_bvalid),
      .dbus_bdata  (dbus_bdata),
      .dbus_bwe    (dbus_bwe),
      .sdr_we_req  (sdr_we_req),
      .sdr_we_ack  (sdr_we_ack),
      .sdr_rd_req  (sdr_rd_req),
      .sdr_rd_ack  (sdr_rd_ack),
      .sdr_cmd     (sdr_cmd),
      .sdr_din     (sdr_din),
      .sdr_dout    (sdr_dout),
      .sdr_r_vld   (sdr_r_vld),
      .sdr_w_rdy   (sdr_w_rdy),
      .rom_en      (rom_en),
      .rom_addr    (rom_addr),
      .rom_dout    (rom_dout)
   );

   bootrom #(
      .ROM_WORDS_LOG2 (ROM_WORDS_LOG2)
   ) u_bootrom (
      .sdr_clk  (sdr_clk),
      .rom_en   (rom_en),
      .rom_addr (rom_addr),
      .rom_dout (rom_dout)
   );

   sdr_burst_ctrl #(
      .READ_LATENCY   (READ_LATENCY),
      .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
   ) u_sdr_ctrl (
      .sdr_clk    (sdr_clk),
      .sdr_rst_n  (sdr_rst_n),
      .sdr_we_req (sdr_we_req),
      .sdr_we_ack (sdr_we_ack),
      .sdr_rd_req (sdr_rd_req),
      .sdr_rd_ack (sdr_rd_ack),
      .sdr_cmd    (sdr_cmd),
      .sdr_din    (sdr_din),
      .sdr_dout   (sdr_dout),
      .sdr_r_vld  (sdr_r_vld),
      .sdr_w_rdy  (sdr_w_rdy)
   );

endmodule

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic word_check(input string name, input logic [bus_pkg::DW-1:0] exp,
                          input logic [bus_pkg::DW-1:0] act);
   if (act !== exp)
   begin
      data_errs++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic beats_check(input string name, input int exp, input int act);
   if (act != exp)
   begin
      count_errs++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
   end
endtask

task automatic level_check(input string name, input logic exp, input logic act);
   if (act !== exp)
   begin
      level_errs++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
   end
endtask

// Beat count first, then each word that both sides have
task automatic burst_check(input string name, input word_q_t exp, input word_q_t got);
   int i;
   beats_check({name, " beats"}, exp.size(), got.size());
   for (i = 0; i < exp.size() && i < got.size(); i++)
      word_check($sformatf("%s beat %0d", name, i), exp[i], got[i]);
endtask

// D-bus burst taking one wr_q word per bwe beat
task automatic dbus_burst(input bus_pkg::dbus_req_t req, output int beats, output int we_beats);
   beats = 0;
   we_beats = 0;
   d_got_q.delete();
   @(negedge sdr_clk);
   dbus_req = req;
   dbus_avalid = 1'b1;
   dbus_wdata = wr_q[0];
   #1;
   while (!dbus_aready)
   begin
      @(negedge sdr_clk);
      #1;
   end
   // Taken on the rising edge in between
   @(negedge sdr_clk);
   dbus_avalid = 1'b0;
   while (!dbus_bvalid)
      @(negedge sdr_clk);
   while (dbus_bvalid)
   begin
      if (dbus_bwe)
      begin
         if (we_beats < wr_q.size())
            dbus_wdata = wr_q[we_beats];
         we_beats++;
      end
      d_got_q.push_back(dbus_bdata);
      beats++;
      @(negedge sdr_clk);
   end
   d_end_cyc = cycle;
endtask

task automatic ibus_burst(input bus_pkg::ibus_req_t req);
   i_got_q.delete();
   @(negedge sdr_clk);
   ibus_req = req;
   ibus_avalid = 1'b1;
   #1;
   while (!ibus_aready)
   begin
      @(negedge sdr_clk);
      #1;
   end
   @(negedge sdr_clk);
   ibus_avalid = 1'b0;
   i_acc_cyc = cycle;
   while (!ibus_bvalid)
      @(negedge sdr_clk);
   while (ibus_bvalid)
   begin
      i_got_q.push_back(ibus_bdata);
      @(negedge sdr_clk);
   end
endtask

`endif

/* tests/tb_dram_subsystem.sv */
module tb_dram_subsystem;

   typedef logic [bus_pkg::DW-1:0] word_q_t[$];

   // About 10 bursts of under 20 cycles each plus reset
   localparam int MAX_CYCLES = 2000;

   logic                   sdr_clk = 1'b0;
   logic                   sdr_rst_n;
   logic                   ibus_avalid;
   bus_pkg::ibus_req_t     ibus_req;
   logic                   ibus_aready;
   logic                   ibus_bready;
   logic                   ibus_bvalid;
   logic [bus_pkg::DW-1:0] ibus_bdata;
   logic                   dbus_avalid;
   bus_pkg::dbus_req_t     dbus_req;
   logic                   dbus_aready;
   logic [bus_pkg::DW-1:0] dbus_wdata;
   logic                   dbus_bready;
   logic                   dbus_bvalid;
   logic [bus_pkg::DW-1:0] dbus_bdata;
   logic                   dbus_bwe;

   int cycle = 0;
   int data_errs = 0;
   int count_errs = 0;
   int level_errs = 0;
   int order_errs = 0;
   int d_end_cyc;
   int i_acc_cyc;
   word_q_t wr_q;
   word_q_t d_got_q;
   word_q_t i_got_q;
   word_q_t line_q;
   word_q_t bank1_q;
   word_q_t bank2_q;
   logic [bus_pkg::DW-1:0] rom_img [0:15];

   dram_subsystem #(
      .READ_LATENCY   (2),
      .MEM_WORDS_LOG2 (6),
      .ROM_WORDS_LOG2 (4)
   ) u_dut (
      .sdr_clk     (sdr_clk),
      .sdr_rst_n   (sdr_rst_n),
      .ibus_avalid (ibus_avalid),
      .ibus_req    (ibus_req),
      .ibus_aready (ibus_aready),
      .ibus_bready (ibus_bready),
      .ibus_bvalid (ibus_bvalid),
      .ibus_bdata  (ibus_bdata),
      .dbus_avalid (dbus_avalid),
      .dbus_req    (dbus_req),
      .dbus_aready (dbus_aready),
      .dbus_wdata  (dbus_wdata),
      .dbus_bready (dbus_bready),
      .dbus_bvalid (dbus_bvalid),
      .dbus_bdata  (dbus_bdata),
      .dbus_bwe    (dbus_bwe)
   );

   `include "tb_checks.svh"

   always #2 sdr_clk = ~sdr_clk;

   always @(posedge sdr_clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= MAX_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   // Byte address of an SDR word in row zero
   function automatic logic [bus_pkg::AW-1:0] sdr_byte_addr(
      input logic [sdr_pkg::BA_BITS-1:0] bank, input logic [sdr_pkg::COL_BITS-1:0] col);
      return {20'd0, bank, col, 1'b0};
   endfunction

   function automatic bus_pkg::dbus_req_t dbus_cmd(input logic [bus_pkg::AW-1:0] addr,
                                                   input logic wr);
      bus_pkg::dbus_req_t r;
      r.addr = addr;
      r.wmsk = {(bus_pkg::DW/8){wr}};
      r.len = bus_pkg::LEN_BITS'(sdr_pkg::BURST_WORDS - 1);
      return r;
   endfunction

   function automatic bus_pkg::ibus_req_t ibus_cmd(input logic [bus_pkg::AW-1:0] addr,
                                                   input logic rom,
                                                   input logic [bus_pkg::LEN_BITS-1:0] len);
      bus_pkg::ibus_req_t r;
      r.addr = addr;
      r.sel_bootrom = rom;
      r.len = len;
      return r;
   endfunction

   task automatic fill_words();
      logic [31:0] r;
      wr_q.delete();
      repeat (sdr_pkg::BURST_WORDS)
      begin
         r = $urandom();
         wr_q.push_back(r[bus_pkg::DW-1:0]);
      end
   endtask

   task automatic reset_state();
      level_check("reset ibus_bvalid", 1'b0, ibus_bvalid);
      level_check("reset dbus_bvalid", 1'b0, dbus_bvalid);
      level_check("reset sdr_we_req", 1'b0, u_dut.sdr_we_req);
      level_check("reset sdr_rd_req", 1'b0, u_dut.sdr_rd_req);
      level_check("reset dbus_aready", 1'b1, dbus_aready);
   endtask

   task automatic write_then_read();
      int beats;
      int we_beats;
      fill_words();
      line_q = wr_q;
      dbus_burst(dbus_cmd(sdr_byte_addr(2'd0, 9'd8), 1'b1), beats, we_beats);
      beats_check("dbus write beats", sdr_pkg::BURST_WORDS, beats);
      beats_check("dbus write bwe beats", sdr_pkg::BURST_WORDS, we_beats);
      dbus_burst(dbus_cmd(sdr_byte_addr(2'd0, 9'd8), 1'b0), beats, we_beats);
      beats_check("dbus read bwe beats", 0, we_beats);
      burst_check("dbus read", line_q, d_got_q);
   endtask

   task automatic ibus_sdr_read();
      ibus_burst(ibus_cmd(sdr_byte_addr(2'd0, 9'd8), 1'b0, 4'd3));
      burst_check("ibus sdr read", line_q, i_got_q);
   endtask

   // Len 7 from word 3 at byte address 6
   task automatic rom_burst();
      word_q_t exp_q;
      logic [3:0] ri;
      ri = 4'd3;
      repeat (8)
      begin
         exp_q.push_back(rom_img[ri]);
         ri = ri + 4'd1;
      end
      ibus_burst(ibus_cmd(32'd6, 1'b1, 4'd7));
      burst_check("boot rom read", exp_q, i_got_q);
   endtask

   // Same column in banks 1 and 2 must not alias
   task automatic bank_split();
      int beats;
      int we_beats;
      fill_words();
      bank1_q = wr_q;
      dbus_burst(dbus_cmd(sdr_byte_addr(2'd1, 9'd4), 1'b1), beats, we_beats);
      fill_words();
      bank2_q = wr_q;
      dbus_burst(dbus_cmd(sdr_byte_addr(2'd2, 9'd4), 1'b1), beats, we_beats);
      dbus_burst(dbus_cmd(sdr_byte_addr(2'd1, 9'd4), 1'b0), beats, we_beats);
      burst_check("bank 1 read", bank1_q, d_got_q);
      dbus_burst(dbus_cmd(sdr_byte_addr(2'd2, 9'd4), 1'b0), beats, we_beats);
      burst_check("bank 2 read", bank2_q, d_got_q);
   endtask

   task automatic dbus_priority();
      int beats;
      int we_beats;
      fork
         dbus_burst(dbus_cmd(sdr_byte_addr(2'd0, 9'd8), 1'b0), beats, we_beats);
         ibus_burst(ibus_cmd(sdr_byte_addr(2'd1, 9'd4), 1'b0, 4'd3));
         begin
            @(negedge sdr_clk);
            #1;
            level_check("priority ibus_aready", 1'b0, ibus_aready);
            level_check("priority dbus_aready", 1'b1, dbus_aready);
         end
      join
      burst_check("priority dbus read", line_q, d_got_q);
      burst_check("priority ibus read", bank1_q, i_got_q);
      if (i_acc_cyc <= d_end_cyc)
      begin
         order_errs++;
         $display("I-bus request was accepted before the D-bus burst had finished");
      end
   endtask

   initial
   begin
      void'($urandom(32'h05963b36));
      $readmemh("boot.hex", rom_img);
      sdr_rst_n = 1'b0;
      ibus_avalid = 1'b0;
      ibus_req = '0;
      ibus_bready = 1'b1;
      dbus_avalid = 1'b0;
      dbus_req = '0;
      dbus_wdata = '0;
      dbus_bready = 1'b1;
      repeat (16) @(posedge sdr_clk);
      @(negedge sdr_clk);
      sdr_rst_n = 1'b1;
      @(negedge sdr_clk);
      reset_state();
      write_then_read();
      ibus_sdr_read();
      rom_burst();
      bank_split();
      dbus_priority();
      $display("Errors: data %0d, beat count %0d, level %0d, ordering %0d",
               data_errs, count_errs, level_errs, order_errs);
      if (data_errs + count_errs + level_errs + order_errs == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

/* boot.hex */
// Boot image, one 16-bit hex word per line, word addresses 0 to 15
a000
b101
c202
d303
e404
f505
0606
1707
2808
3909
4a0a
5b0b
6c0c
7d0d
8e0e
9f0f

/* sim.f */
+incdir+tests
verilog/sdr_pkg.sv
verilog/bus_pkg.sv
verilog/bootrom.sv
verilog/sdr_burst_ctrl.sv
verilog/dram_arbiter.sv
verilog/dram_subsystem.sv
tests/tb_dram_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_dram_subsystem
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_dram_subsystem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation returned status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1
